// ==== Bender.yml ====
package:
  name: dlx_core

sources:
  - src/dlx_pkg.sv
  - src/dlx_fetch.sv
  - src/dlx_hazard.sv
  - src/dlx_decode.sv
  - src/dlx_execute.sv
  - src/dlx_writeback.sv
  - src/dlx_core.sv
  - target: test
    files:
      - tb/dlx_clk_gen.sv
      - tb/dlx_tb.sv

// ==== dlx_core.f ====
src/dlx_pkg.sv
src/dlx_fetch.sv
src/dlx_hazard.sv
src/dlx_decode.sv
src/dlx_execute.sv
src/dlx_writeback.sv
src/dlx_core.sv
tb/dlx_clk_gen.sv
tb/dlx_tb.sv

// ==== src/dlx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_core #(
    parameter dlx_pkg::word_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    output dlx_pkg::word_t     imem_addr,
    input  dlx_pkg::word_t     imem_data,
    output dlx_pkg::dmem_req_t dmem_req,
    input  dlx_pkg::word_t     dmem_rdata
);

    ////////////////////////////////////////////////////////////////////////////
    // stage to stage nets
    ////////////////////////////////////////////////////////////////////////////

    logic              stall;
    dlx_pkg::word_t    if_instr;
    dlx_pkg::id_ex_t   id_ex;
    dlx_pkg::ex_mem_t  ex_mem;
    dlx_pkg::wb_t      wb;
    dlx_pkg::fwd_sel_t fwd_a;
    dlx_pkg::fwd_sel_t fwd_b;

    dlx_fetch #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .if_instr  (if_instr)
    );

    // load-use stall and EX operand selects
    dlx_hazard i_hazard (
        .imem_data (imem_data),
        .if_instr  (if_instr),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .wb        (wb),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    dlx_decode i_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_instr (if_instr),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    dlx_execute i_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .wb     (wb),
        .ex_mem (ex_mem)
    );

    dlx_writeback i_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    // MEM stage is just the data memory port
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.we    = ex_mem.mem_write;

endmodule

`default_nettype wire

// ==== src/dlx_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_decode (
    input  logic            clk,
    input  logic            rst_n,
    input  dlx_pkg::word_t  if_instr,
    input  dlx_pkg::wb_t    wb,
    output dlx_pkg::id_ex_t id_ex
);

    dlx_pkg::word_t     regs [32];
    dlx_pkg::ctrl_t     ctrl;
    dlx_pkg::reg_addr_t rs1;
    dlx_pkg::reg_addr_t rs2;
    dlx_pkg::reg_addr_t rd;
    dlx_pkg::word_t     imm;
    dlx_pkg::word_t     rs1_val;
    dlx_pkg::word_t     rs2_val;
    logic [5:0]         opcode;
    logic [5:0]         funct;

    ////////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = if_instr[31:26];
    assign funct  = if_instr[5:0];
    assign rs1    = if_instr[25:21];
    assign rs2    = if_instr[20:16];
    // i-type writes the rs2 field
    assign rd     = (opcode == dlx_pkg::op_special) ? if_instr[15:11] : if_instr[20:16];
    assign imm    = {{16{if_instr[15]}}, if_instr[15:0]};

    // control decode
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = dlx_pkg::alu_add;
        case (opcode)
            dlx_pkg::op_special: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    dlx_pkg::fn_add: ctrl.alu_op = dlx_pkg::alu_add;
                    dlx_pkg::fn_sub: ctrl.alu_op = dlx_pkg::alu_sub;
                    dlx_pkg::fn_and: ctrl.alu_op = dlx_pkg::alu_and;
                    dlx_pkg::fn_or:  ctrl.alu_op = dlx_pkg::alu_or;
                    dlx_pkg::fn_slt: ctrl.alu_op = dlx_pkg::alu_slt;
                    // unknown function, incl. the zero bubble
                    default:         ctrl.reg_write = 1'b0;
                endcase
            end
            dlx_pkg::op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            dlx_pkg::op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.use_imm    = 1'b1;
            end
            dlx_pkg::op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // register file, written from WB
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // r0 reads zero
    // same-cycle WB write goes straight through to the read
    always_comb begin
        rs1_val = (rs1 == '0) ? '0 : regs[rs1];
        rs2_val = (rs2 == '0) ? '0 : regs[rs2];
        if (wb.we && (wb.rd != '0) && (wb.rd == rs1)) begin
            rs1_val = wb.value;
        end
        if (wb.we && (wb.rd != '0) && (wb.rd == rs2)) begin
            rs2_val = wb.value;
        end
    end

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl    <= ctrl;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.imm     <= imm;
            id_ex.rs1     <= rs1;
            id_ex.rs2     <= rs2;
            id_ex.rd      <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/dlx_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  dlx_pkg::id_ex_t   id_ex,
    input  dlx_pkg::fwd_sel_t fwd_a,
    input  dlx_pkg::fwd_sel_t fwd_b,
    input  dlx_pkg::wb_t      wb,
    output dlx_pkg::ex_mem_t  ex_mem
);

    // one operand mux, used for both sources
    function automatic dlx_pkg::word_t fwd_mux(input dlx_pkg::fwd_sel_t sel,
                                               input dlx_pkg::word_t    reg_val,
                                               input dlx_pkg::word_t    mem_val,
                                               input dlx_pkg::word_t    wb_val);
        case (sel)
            dlx_pkg::from_mem: return mem_val;
            dlx_pkg::from_wb:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    dlx_pkg::word_t op_a;
    dlx_pkg::word_t rs2_fwd;
    dlx_pkg::word_t op_b;
    dlx_pkg::word_t alu_y;

    // MEM value comes back from our own EX/MEM register
    assign op_a    = fwd_mux(fwd_a, id_ex.rs1_val, ex_mem.alu_result, wb.value);
    assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_val, ex_mem.alu_result, wb.value);
    // store data stays rs2, addi/lw/sw take the immediate on B
    assign op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;

    // ALU
    always_comb begin
        case (id_ex.ctrl.alu_op)
            dlx_pkg::alu_add: alu_y = op_a + op_b;
            dlx_pkg::alu_sub: alu_y = op_a - op_b;
            dlx_pkg::alu_and: alu_y = op_a & op_b;
            dlx_pkg::alu_or:  alu_y = op_a | op_b;
            // signed set-less-than
            dlx_pkg::alu_slt: alu_y = {{(dlx_pkg::xlen-1){1'b0}},
                                       ($signed(op_a) < $signed(op_b))};
            default:          alu_y = op_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= rs2_fwd;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/dlx_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_fetch #(
    parameter dlx_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  dlx_pkg::word_t imem_data,
    output dlx_pkg::word_t imem_addr,
    output dlx_pkg::word_t if_instr
);

    localparam dlx_pkg::word_t pc_step = 4;

    dlx_pkg::word_t pc;

    // imem read is combinational off the current pc
    assign imem_addr = pc;

    // pc holds while the load-use stall is up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= pc + pc_step;
        end
    end

    // IF/ID register
    // stall loads the zero word, an r-type with rd 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr <= '0;
        end else if (stall) begin
            if_instr <= '0;
        end else begin
            if_instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/dlx_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_hazard (
    input  dlx_pkg::word_t    imem_data,
    input  dlx_pkg::word_t    if_instr,
    input  dlx_pkg::id_ex_t   id_ex,
    input  dlx_pkg::ex_mem_t  ex_mem,
    input  dlx_pkg::wb_t      wb,
    output logic              stall,
    output dlx_pkg::fwd_sel_t fwd_a,
    output dlx_pkg::fwd_sel_t fwd_b
);

    // MEM first, then WB, otherwise the value read in ID
    function automatic dlx_pkg::fwd_sel_t pick_src(input dlx_pkg::reg_addr_t rs,
                                                   input dlx_pkg::ex_mem_t   mem,
                                                   input dlx_pkg::wb_t       res);
        logic mem_hit;
        logic wb_hit;
        // a load in MEM has no data yet
        mem_hit = mem.reg_write && !mem.mem_to_reg && (mem.rd != '0) && (mem.rd == rs);
        wb_hit  = res.we && (res.rd != '0) && (res.rd == rs);
        if (mem_hit) begin
            return dlx_pkg::from_mem;
        end else if (wb_hit) begin
            return dlx_pkg::from_wb;
        end
        return dlx_pkg::from_reg;
    endfunction

    logic                id_is_load;
    dlx_pkg::reg_addr_t  id_load_rd;

    // load sitting in ID, its rd is the i-type field
    assign id_is_load = (if_instr[31:26] == dlx_pkg::op_lw);
    assign id_load_rd = if_instr[20:16];

    // word in IF reads the load target on either source field
    assign stall = id_is_load && (id_load_rd != '0) &&
                   ((id_load_rd == imem_data[25:21]) || (id_load_rd == imem_data[20:16]));

    assign fwd_a = pick_src(id_ex.rs1, ex_mem, wb);
    assign fwd_b = pick_src(id_ex.rs2, ex_mem, wb);

endmodule

`default_nettype wire

// ==== src/dlx_pkg.sv ====
`default_nettype none

package dlx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and basic types
    ////////////////////////////////////////////////////////////////////////////

    parameter int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // major opcodes, instr[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // r-type function field, instr[5:0]
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    // operand source for the instruction in EX
    typedef enum logic [1:0] {
        from_reg,
        from_mem,
        from_wb
    } fwd_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // stage payloads, all zeros is a nop
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    use_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    // write-back result, also the bypass and forwarding source
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     value;
    } wb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== src/dlx_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_writeback (
    input  logic             clk,
    input  logic             rst_n,
    input  dlx_pkg::ex_mem_t ex_mem,
    input  dlx_pkg::word_t   dmem_rdata,
    output dlx_pkg::wb_t     wb
);

    logic               we_q;
    logic               mem_to_reg_q;
    dlx_pkg::reg_addr_t rd_q;
    dlx_pkg::word_t     alu_result_q;
    dlx_pkg::word_t     load_data_q;

    // MEM/WB register
    // dmem_rdata is the combinational read at this cycle's address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q         <= 1'b0;
            mem_to_reg_q <= 1'b0;
            rd_q         <= '0;
            alu_result_q <= '0;
            load_data_q  <= '0;
        end else begin
            we_q         <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
            rd_q         <= ex_mem.rd;
            alu_result_q <= ex_mem.alu_result;
            load_data_q  <= dmem_rdata;
        end
    end

    // result toward regfile, bypass and forwarding
    assign wb.we    = we_q;
    assign wb.rd    = rd_q;
    assign wb.value = mem_to_reg_q ? load_data_q : alu_result_q;

endmodule

`default_nettype wire

// ==== tb/dlx_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_clk_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    // free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

    // release 1 ns after an edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/dlx_golden.mem ====
// word 0: program length, then the program words from address 0
// then the store count, then one expected store per line: address data
0000001c
2001fffb
2002000c
00221820
00222022
00222824
00223025
0022382a
ac030000
ac040004
ac050008
ac06000c
ac070010
20080003
01084820
01285022
ad2a001a
200c0009
200b0028
ad6c0004
200d0064
200e0008
00000000
adcd0028
200f004d
ac0f0034
8c100034
020f8820
ac110038
0000000a
00000000 00000007
00000004 ffffffef
00000008 00000008
0000000c ffffffff
00000010 00000001
00000020 00000003
0000002c 00000009
00000030 00000064
00000034 0000004d
00000038 0000009a

// ==== tb/dlx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dlx_tb;

    localparam dlx_pkg::word_t reset_pc = '0;
    localparam int imem_words   = 64;
    localparam int dmem_words   = 64;
    localparam int golden_words = 128;
    localparam int drain_cycles = 8;

    logic               clk;
    logic               rst_n;
    dlx_pkg::word_t     imem_addr;
    dlx_pkg::word_t     imem_data;
    dlx_pkg::dmem_req_t dmem_req;
    dlx_pkg::word_t     dmem_rdata;

    dlx_pkg::word_t     golden [golden_words];
    dlx_pkg::word_t     imem [imem_words];
    dlx_pkg::word_t     dmem [dmem_words];
    dlx_pkg::dmem_req_t exp_stores [$];
    // MEM request seen mid-cycle, committed on the next rising edge
    dlx_pkg::dmem_req_t wr_req = '0;

    int prog_len;
    int test_count;
    int fail_count;

    dlx_clk_gen #(
        .period_ns    (4),
        .reset_cycles (3)
    ) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dlx_core #(
        .reset_pc (reset_pc)
    ) i_dlx_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory models
    ////////////////////////////////////////////////////////////////////////////

    // zero past the end of the program
    function automatic dlx_pkg::word_t imem_word(input dlx_pkg::word_t addr);
        int unsigned idx;
        idx = addr >> 2;
        if (idx < imem_words) begin
            return imem[idx];
        end
        return '0;
    endfunction

    function automatic dlx_pkg::word_t dmem_word(input dlx_pkg::word_t addr);
        int unsigned idx;
        idx = addr >> 2;
        if (idx < dmem_words) begin
            return dmem[idx];
        end
        return '0;
    endfunction

    always @(negedge clk) begin
        wr_req = dmem_req;
    end

    // write first, so a load right behind a store sees the new word
    always @(posedge clk) begin : mem_model
        int unsigned idx;
        #1;
        if (rst_n && wr_req.we) begin
            idx = wr_req.addr >> 2;
            if (idx < dmem_words) begin
                dmem[idx] = wr_req.wdata;
            end
        end
        imem_data  = imem_word(imem_addr);
        dmem_rdata = dmem_word(dmem_req.addr);
    end

    ////////////////////////////////////////////////////////////////////////////
    // golden file and compares
    ////////////////////////////////////////////////////////////////////////////

    // count, program words, count, then address/data pairs
    task automatic load_golden();
        int n_stores;
        int base;
        int i;
        $readmemh("tb/dlx_golden.mem", golden);
        foreach (imem[k]) begin
            imem[k] = '0;
        end
        foreach (dmem[k]) begin
            dmem[k] = '0;
        end
        prog_len = golden[0];
        if (prog_len < 1 || prog_len > imem_words) begin
            $display("golden file gives a program of %0d words, which does not fit", prog_len);
            fail_count++;
            prog_len = 0;
            return;
        end
        for (i = 0; i < prog_len; i++) begin
            imem[i] = golden[i + 1];
        end
        n_stores = golden[prog_len + 1];
        base     = prog_len + 2;
        if (n_stores < 0 || base + 2 * n_stores > golden_words) begin
            $display("golden file lists %0d stores, more than it can hold", n_stores);
            fail_count++;
            return;
        end
        for (i = 0; i < n_stores; i++) begin
            exp_stores.push_back('{addr: golden[base + 2 * i],
                                   wdata: golden[base + 2 * i + 1],
                                   we: 1'b1});
        end
    endtask

    task automatic check_word(input dlx_pkg::word_t got, input dlx_pkg::word_t exp,
                              input string what);
        test_count++;
        if (got !== exp) begin
            fail_count++;
            $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end else begin
            $display("%s ok: 0x%08h", what, got);
        end
    endtask

    task automatic check_store(input dlx_pkg::dmem_req_t got, input dlx_pkg::dmem_req_t exp,
                               input int idx);
        test_count++;
        if (got.addr !== exp.addr || got.wdata !== exp.wdata) begin
            fail_count++;
            $display("mismatch at %0t: store %0d wrote 0x%08h to 0x%08h, expected 0x%08h to 0x%08h",
                     $time, idx, got.wdata, got.addr, exp.wdata, exp.addr);
        end else begin
            $display("store %0d ok: 0x%08h at 0x%08h", idx, got.wdata, got.addr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////////////////////

    initial begin : run
        int cycles;
        int limit;
        int seen;
        int extra;
        imem_data  = '0;
        dmem_rdata = '0;
        test_count = 0;
        fail_count = 0;
        load_golden();
        // one cycle per word plus stalls, with plenty of slack
        limit = 4 * prog_len + 40;

        @(posedge rst_n);
        @(negedge clk);
        check_word(imem_addr, reset_pc, "imem_addr after reset");

        // every store is compared in order, early ones included
        seen   = 0;
        cycles = 0;
        while (seen < exp_stores.size() && cycles < limit) begin
            if (dmem_req.we) begin
                check_store(dmem_req, exp_stores[seen], seen);
                seen++;
            end
            cycles++;
            @(negedge clk);
        end

        test_count++;
        if (seen < exp_stores.size()) begin
            fail_count++;
            $display("timeout after %0d cycles: only %0d of %0d expected stores arrived",
                     cycles, seen, exp_stores.size());
        end else begin
            // trailing nops must not write
            extra = 0;
            repeat (drain_cycles) begin
                if (dmem_req.we) begin
                    extra++;
                end
                @(negedge clk);
            end
            if (extra != 0) begin
                fail_count++;
                $display("%0d stores showed up after the last expected one", extra);
            end else begin
                $display("all %0d stores arrived in order within %0d cycles", seen, cycles);
            end
        end

        $display("%0d tests, %0d passed, %0d failed",
                 test_count, test_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
